// File: Makefile
# Verilator build for the MIPS execute slice
VERILATOR ?= verilator
TOP       ?= mips_exec_core_tb
FILELIST  ?= mips_exec_core.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exits with a failing status when the testbench stops on $fatal
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: hw/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute import mips_exec_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       i_rst_n,
    input  wire logic       i_valid,
    input  wire ctrl_word_t i_ctrl,
    input  wire word_t      i_instr,
    input  wire word_t      i_rs_val,
    input  wire word_t      i_rt_val,
    input  wire word_t      i_pc_next,
    output logic            o_valid,
    output exec_word_t      o_exec
);

    logic [15:0] imm;
    logic [4:0]  shamt;
    logic [4:0]  sh_amt;
    word_t       imm_sext;
    word_t       imm_ext;
    word_t       op_a;
    word_t       op_b;
    word_t       alu_res;
    exec_word_t  nxt;

    assign imm      = i_instr[15:0];
    assign shamt    = i_instr[10:6];
    assign imm_sext = {{16{imm[15]}}, imm};

    always_comb begin
        case (i_ctrl.ext_mode)
            MODE_ZERO_EXT_UPPER: imm_ext = {16'b0, imm};
            MODE_ZERO_EXT_LOWER: imm_ext = {imm, 16'b0};    // LUI form
            default:             imm_ext = imm_sext;
        endcase
    end

    always_comb begin
        case (i_ctrl.src_a)
            SRC_A_IMM: op_a = imm_ext;
            SRC_A_PC4: op_a = i_pc_next;
            default:   op_a = i_rs_val;
        endcase
    end

    // With an immediate in A, the register operand moves to B
    assign op_b   = (i_ctrl.src_a == SRC_A_IMM) ? i_rs_val : i_rt_val;
    assign sh_amt = i_ctrl.shamt_sel ? shamt : op_a[4:0];   // Variable shifts use RS[4:0]

    always_comb begin
        case (i_ctrl.alu_op)
            OP_SHIFT_LEFT:       alu_res = op_b << sh_amt;  // Shifted value is RT
            OP_SHIFT_RIGHT:      alu_res = op_b >> sh_amt;
            OP_SHIFT_RIGHT_ARIT: alu_res = word_t'($signed(op_b) >>> sh_amt);
            OP_ADD:              alu_res = op_a + op_b;
            OP_SIGNED_ADD:       alu_res = op_a + op_b;     // No overflow trap in this slice
            OP_SUB:              alu_res = op_a - op_b;
            OP_AND:              alu_res = op_a & op_b;
            OP_OR:               alu_res = op_a | op_b;
            OP_XOR:              alu_res = op_a ^ op_b;
            OP_NOR:              alu_res = ~(op_a | op_b);
            OP_SLT:              alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            OP_CMP:              alu_res = {31'b0, $signed(op_b) < $signed(op_a)};
            default:             alu_res = op_a;            // Pass
        endcase
    end

    always_comb begin
        nxt            = '0;
        nxt.ctrl       = i_ctrl;
        nxt.alu_res    = alu_res;
        nxt.eq         = (i_rs_val == i_rt_val);            // Branch condition source
        nxt.mem_addr   = i_rs_val + imm_sext;
        nxt.store_data = i_rt_val;
        nxt.br_target  = i_pc_next + {imm_sext[29:0], 2'b00};
        nxt.jmp_target = i_ctrl.jmp_reg ? i_rs_val
                                        : {i_pc_next[31:28], i_instr[25:0], 2'b00};
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) o_exec <= nxt;                 // Payload, held until the next instruction
    end

endmodule

`default_nettype wire

// File: hw/ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_decode import mips_exec_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       i_rst_n,
    input  wire logic       i_load,                 // One-cycle strobe from the handshake FSM
    input  wire word_t      i_instr,
    input  wire word_t      i_rs_val,
    input  wire word_t      i_rt_val,
    input  wire word_t      i_pc_next,
    output logic            o_valid,
    output ctrl_word_t      o_ctrl,
    output word_t           o_instr,
    output word_t           o_rs_val,
    output word_t           o_rt_val,
    output word_t           o_pc_next
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rt_idx;
    reg_idx_t   rd_idx;
    ctrl_word_t dec;

    assign opcode = i_instr[31:26];
    assign funct  = i_instr[5:0];
    assign rt_idx = i_instr[20:16];
    assign rd_idx = i_instr[15:11];

    always_comb begin
        dec          = '0;                          // Unknown codes stay a NOP with enables low
        dec.alu_op   = OP_PASS;
        dec.src_a    = SRC_A_RS;
        dec.ext_mode = MODE_SIGN_EXT;
        case (opcode)
            OPC_RTYPE: begin
                dec.dst_reg = rd_idx;
                dec.reg_wr  = 1'b1;                 // Cleared below for JR and unknown functions
                case (funct)
                    FUNC_SLL:  begin dec.shamt_sel = 1'b1; dec.alu_op = OP_SHIFT_LEFT; end
                    FUNC_SRL:  begin dec.shamt_sel = 1'b1; dec.alu_op = OP_SHIFT_RIGHT; end
                    FUNC_SRA:  begin dec.shamt_sel = 1'b1; dec.alu_op = OP_SHIFT_RIGHT_ARIT; end
                    FUNC_SLLV: dec.alu_op = OP_SHIFT_LEFT;
                    FUNC_SRLV: dec.alu_op = OP_SHIFT_RIGHT;
                    FUNC_SRAV: dec.alu_op = OP_SHIFT_RIGHT_ARIT;
                    FUNC_ADDU: dec.alu_op = OP_ADD;
                    FUNC_SUBU: dec.alu_op = OP_SUB;
                    FUNC_AND:  dec.alu_op = OP_AND;
                    FUNC_OR:   dec.alu_op = OP_OR;
                    FUNC_XOR:  dec.alu_op = OP_XOR;
                    FUNC_NOR:  dec.alu_op = OP_NOR;
                    FUNC_SLT:  dec.alu_op = OP_SLT;
                    FUNC_JR: begin
                        dec.reg_wr  = 1'b0;
                        dec.jump    = 1'b1;
                        dec.jmp_reg = 1'b1;
                    end
                    FUNC_JALR: begin
                        dec.src_a   = SRC_A_PC4;    // Return address goes to RD
                        dec.jump    = 1'b1;
                        dec.jmp_reg = 1'b1;
                    end
                    default: dec.reg_wr = 1'b0;
                endcase
            end
            OPC_ADDI, OPC_SLTI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI: begin
                dec.src_a   = SRC_A_IMM;
                dec.dst_reg = rt_idx;               // Immediates write RT
                dec.reg_wr  = 1'b1;
                case (opcode)
                    OPC_ADDI: dec.alu_op = OP_SIGNED_ADD;
                    OPC_SLTI: dec.alu_op = OP_CMP;
                    OPC_ANDI: begin dec.alu_op = OP_AND; dec.ext_mode = MODE_ZERO_EXT_UPPER; end
                    OPC_ORI:  begin dec.alu_op = OP_OR;  dec.ext_mode = MODE_ZERO_EXT_UPPER; end
                    OPC_XORI: begin dec.alu_op = OP_XOR; dec.ext_mode = MODE_ZERO_EXT_UPPER; end
                    default:  dec.ext_mode = MODE_ZERO_EXT_LOWER;  // LUI passes imm << 16
                endcase
            end
            OPC_LW: begin
                dec.dst_reg = rt_idx;               // Written later by the memory stage
                dec.mem_rd  = 1'b1;
            end
            OPC_SW:  dec.mem_wr = 1'b1;
            OPC_BEQ, OPC_BNE: begin
                dec.alu_op = OP_SUB;
                dec.branch = 1'b1;
                dec.bne    = opcode[0];             // BNE differs from BEQ in bit 0
            end
            OPC_J:   dec.jump = 1'b1;
            OPC_JAL: begin
                dec.src_a   = SRC_A_PC4;
                dec.dst_reg = 5'd31;                // Link register
                dec.reg_wr  = 1'b1;
                dec.jump    = 1'b1;
            end
            OPC_HALT: dec.halt = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_ctrl  <= '0;                          // All enables low out of reset
        end else begin
            o_valid <= i_load;                      // Valid one cycle after the load strobe
            if (i_load) o_ctrl <= dec;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            o_instr   <= i_instr;
            o_rs_val  <= i_rs_val;
            o_rt_val  <= i_rt_val;
            o_pc_next <= i_pc_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/exec_result.sv
`timescale 1ns/1ps
`default_nettype none

module exec_result import mips_exec_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       i_rst_n,
    input  wire logic       i_valid,
    input  wire exec_word_t i_exec,
    output exe_result_t     o_result
);

    logic        taken;
    exe_result_t nxt;

    // BNE inverts the equality test
    assign taken = i_exec.ctrl.branch & (i_exec.ctrl.bne ^ i_exec.eq);

    always_comb begin
        nxt.wb_en       = i_exec.ctrl.reg_wr;
        nxt.wb_reg      = i_exec.ctrl.dst_reg;
        nxt.wb_data     = i_exec.alu_res;
        nxt.mem_rd_en   = i_exec.ctrl.mem_rd;
        nxt.mem_wr_en   = i_exec.ctrl.mem_wr;
        nxt.mem_addr    = i_exec.mem_addr;
        nxt.mem_data    = i_exec.store_data;
        nxt.pc_redirect = i_exec.ctrl.jump | taken; // Jumps always redirect
        nxt.pc_target   = i_exec.ctrl.jump ? i_exec.jmp_target : i_exec.br_target;
        nxt.halt        = i_exec.ctrl.halt;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_result.wb_en       <= 1'b0;
            o_result.mem_rd_en   <= 1'b0;
            o_result.mem_wr_en   <= 1'b0;
            o_result.pc_redirect <= 1'b0;
            o_result.halt        <= 1'b0;
        end else if (i_valid) begin
            o_result <= nxt;                        // Stays put while the core holds o_ack
        end
    end

endmodule

`default_nettype wire

// File: hw/mips_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_exec_core import mips_exec_pkg::*; (
    input  wire logic   i_clk,
    input  wire logic   i_rst_n,
    input  wire logic   i_req,                      // Four-phase request from the issue stage
    input  wire word_t  i_instr,
    input  wire word_t  i_rs_val,
    input  wire word_t  i_rt_val,
    input  wire word_t  i_pc_next,
    output logic        o_ack,
    output exe_result_t o_result
);

    hs_state_t  state;
    logic       load;
    logic       dec_valid;
    logic       exe_valid;
    ctrl_word_t dec_ctrl;
    word_t      dec_instr;
    word_t      dec_rs_val;
    word_t      dec_rt_val;
    word_t      dec_pc_next;
    exec_word_t exe_word;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= IDLE;
            load  <= 1'b0;
        end else begin
            load <= (state == IDLE) && i_req;       // Single pulse, state leaves IDLE at once
            case (state)
                IDLE: if (i_req) state <= BUSY;
                BUSY: if (exe_valid) state <= DONE; // Result registers at this same edge
                DONE: if (!i_req) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign o_ack = (state == DONE);                 // High exactly while DONE holds the result

    ctrl_decode u_ctrl_decode (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_load    (load),
        .i_instr   (i_instr),
        .i_rs_val  (i_rs_val),
        .i_rt_val  (i_rt_val),
        .i_pc_next (i_pc_next),
        .o_valid   (dec_valid),
        .o_ctrl    (dec_ctrl),
        .o_instr   (dec_instr),
        .o_rs_val  (dec_rs_val),
        .o_rt_val  (dec_rt_val),
        .o_pc_next (dec_pc_next)
    );

    alu_execute u_alu_execute (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (dec_valid),
        .i_ctrl    (dec_ctrl),
        .i_instr   (dec_instr),
        .i_rs_val  (dec_rs_val),
        .i_rt_val  (dec_rt_val),
        .i_pc_next (dec_pc_next),
        .o_valid   (exe_valid),
        .o_exec    (exe_word)
    );

    exec_result u_exec_result (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (exe_valid),
        .i_exec   (exe_word),
        .o_result (o_result)
    );

endmodule

`default_nettype wire

// File: hw/mips_exec_pkg.sv
`default_nettype none

package mips_exec_pkg;

    typedef logic [31:0] word_t;                    // Data word, address or instruction
    typedef logic [4:0]  reg_idx_t;                 // Register file index
    typedef logic [3:0]  alu_op_t;                  // ALU operation code
    typedef logic [1:0]  ext_mode_t;                // Immediate extension mode
    typedef logic [1:0]  src_a_t;                   // Operand A selector

    localparam alu_op_t OP_SHIFT_LEFT       = 4'b0001;
    localparam alu_op_t OP_SHIFT_RIGHT      = 4'b0000;
    localparam alu_op_t OP_SHIFT_RIGHT_ARIT = 4'b0010;
    localparam alu_op_t OP_PASS             = 4'b0011;  // Operand A straight through
    localparam alu_op_t OP_ADD              = 4'b0100;
    localparam alu_op_t OP_SUB              = 4'b0101;
    localparam alu_op_t OP_AND              = 4'b0110;
    localparam alu_op_t OP_OR               = 4'b0111;
    localparam alu_op_t OP_XOR              = 4'b1000;
    localparam alu_op_t OP_NOR              = 4'b1001;
    localparam alu_op_t OP_SLT              = 4'b1010;  // Signed A below B
    localparam alu_op_t OP_CMP              = 4'b1011;  // Signed B below A, used by SLTI
    localparam alu_op_t OP_SIGNED_ADD       = 4'b1100;

    localparam ext_mode_t MODE_SIGN_EXT       = 2'b00;
    localparam ext_mode_t MODE_ZERO_EXT_UPPER = 2'b01;  // Upper half filled with zeros
    localparam ext_mode_t MODE_ZERO_EXT_LOWER = 2'b10;  // Lower half filled with zeros

    localparam src_a_t SRC_A_PC4 = 2'b00;           // Return address for link instructions
    localparam src_a_t SRC_A_RS  = 2'b01;
    localparam src_a_t SRC_A_IMM = 2'b11;           // Extended immediate, B becomes RS

    localparam logic [5:0] OPC_RTYPE = 6'b000000;
    localparam logic [5:0] OPC_J     = 6'b000010;
    localparam logic [5:0] OPC_JAL   = 6'b000011;
    localparam logic [5:0] OPC_BEQ   = 6'b000100;
    localparam logic [5:0] OPC_BNE   = 6'b000101;
    localparam logic [5:0] OPC_ADDI  = 6'b001000;
    localparam logic [5:0] OPC_SLTI  = 6'b001010;
    localparam logic [5:0] OPC_ANDI  = 6'b001100;
    localparam logic [5:0] OPC_ORI   = 6'b001101;
    localparam logic [5:0] OPC_XORI  = 6'b001110;
    localparam logic [5:0] OPC_LUI   = 6'b001111;
    localparam logic [5:0] OPC_LW    = 6'b100011;
    localparam logic [5:0] OPC_SW    = 6'b101011;
    localparam logic [5:0] OPC_HALT  = 6'b111111;

    localparam logic [5:0] FUNC_SLL  = 6'b000000;
    localparam logic [5:0] FUNC_SRL  = 6'b000010;
    localparam logic [5:0] FUNC_SRA  = 6'b000011;
    localparam logic [5:0] FUNC_SLLV = 6'b000100;
    localparam logic [5:0] FUNC_SRLV = 6'b000110;
    localparam logic [5:0] FUNC_SRAV = 6'b000111;
    localparam logic [5:0] FUNC_JR   = 6'b001000;
    localparam logic [5:0] FUNC_JALR = 6'b001001;
    localparam logic [5:0] FUNC_ADDU = 6'b100001;
    localparam logic [5:0] FUNC_SUBU = 6'b100011;
    localparam logic [5:0] FUNC_AND  = 6'b100100;
    localparam logic [5:0] FUNC_OR   = 6'b100101;
    localparam logic [5:0] FUNC_XOR  = 6'b100110;
    localparam logic [5:0] FUNC_NOR  = 6'b100111;
    localparam logic [5:0] FUNC_SLT  = 6'b101010;

    typedef struct packed {
        alu_op_t   alu_op;
        src_a_t    src_a;
        logic      shamt_sel;                       // Shift amount from the SA field
        ext_mode_t ext_mode;
        reg_idx_t  dst_reg;
        logic      reg_wr;
        logic      mem_rd;
        logic      mem_wr;
        logic      jump;
        logic      branch;
        logic      bne;                             // Branch taken on inequality
        logic      jmp_reg;                         // Jump target comes from RS
        logic      halt;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        word_t      alu_res;
        logic       eq;                             // RS equals RT
        word_t      mem_addr;
        word_t      store_data;
        word_t      br_target;
        word_t      jmp_target;
    } exec_word_t;

    typedef struct packed {
        logic     wb_en;
        reg_idx_t wb_reg;
        word_t    wb_data;
        logic     mem_rd_en;
        logic     mem_wr_en;
        word_t    mem_addr;
        word_t    mem_data;
        logic     pc_redirect;
        word_t    pc_target;
        logic     halt;
    } exe_result_t;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } hs_state_t;

endpackage

`default_nettype wire

// File: mips_exec_core.f
hw/mips_exec_pkg.sv
hw/ctrl_decode.sv
hw/alu_execute.sv
hw/exec_result.sv
hw/mips_exec_core.sv
verif/mips_exec_core_sva.sv
verif/mips_exec_core_tb.sv

// File: verif/mips_exec_core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mips_exec_core_sva import mips_exec_pkg::*; (
    input  wire logic        i_clk,
    input  wire logic        i_rst_n,
    input  wire logic        i_req,                 // Request from the issue stage
    input  wire logic        i_ack,                 // Core acknowledge
    input  wire exe_result_t i_result               // Core result bundle
);

    logic any_enable;
    int   fail_count = 0;                           // Failed assertion attempts so far

    assign any_enable = i_result.wb_en | i_result.mem_rd_en | i_result.mem_wr_en
                      | i_result.pc_redirect | i_result.halt;

    reset_quiet: assert property (@(posedge i_clk) !i_rst_n |=> (!i_ack && !any_enable))
        else begin
            $error("Acknowledge or a result enable is high after reset");
            fail_count++;
        end

    // The request must already be high at the edge that raises the acknowledge
    ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_ack) |-> $past(i_req))
        else begin
            $error("Acknowledge rose without a request");
            fail_count++;
        end

    result_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_ack && $past(i_ack)) |-> $stable(i_result))
        else begin
            $error("Result changed while the acknowledge was high");
            fail_count++;
        end

    ack_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_ack && i_req) |=> i_ack)
        else begin
            $error("Acknowledge dropped while the request was still high");
            fail_count++;
        end

    ack_drop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_ack && !i_req) |=> !i_ack)
        else begin
            $error("Acknowledge did not fall one cycle after the request");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: verif/mips_exec_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_exec_core_tb import mips_exec_pkg::*; ();

    localparam int    CLK_PERIOD     = 4;
    localparam int    DRIVE_DELAY    = 1;               // Inputs change 1 ns after the edge
    localparam int    RESET_CYCLES   = 4;
    localparam int    NUM_PATTERNS   = 27;
    localparam int    FIELDS         = 14;              // Hex tokens per pattern line
    localparam int    NUM_WORDS      = NUM_PATTERNS * FIELDS;
    localparam int    TIMEOUT_CYCLES = NUM_PATTERNS * 10 + 20;
    localparam string PATTERN_FILE   = "verif/mips_exec_patterns.txt";

    typedef struct packed {
        word_t       instr;
        word_t       rs_val;
        word_t       rt_val;
        word_t       pc_next;
        exe_result_t exp;                               // Expected result of the exchange
    } pattern_t;

    logic        clk;
    logic        rst_n;
    logic        req;
    word_t       instr;
    word_t       rs_val;
    word_t       rt_val;
    word_t       pc_next;
    logic        ack;
    exe_result_t result;

    word_t       pat_words [0:NUM_WORDS-1];             // Flat image of the pattern file
    pattern_t    cur;
    int          pat_idx;
    int          cycle_cnt = 0;

    mips_exec_core dut0 (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_req     (req),
        .i_instr   (instr),
        .i_rs_val  (rs_val),
        .i_rt_val  (rt_val),
        .i_pc_next (pc_next),
        .o_ack     (ack),
        .o_result  (result)
    );

    bind mips_exec_core mips_exec_core_sva u_handshake_sva (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_req    (i_req),
        .i_ack    (o_ack),
        .i_result (o_result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic fail_on_mismatch(input string name, input word_t got, input word_t exp);
        $display("ERROR: %s = 0x%0h, expected 0x%0h (pattern %0d, instr 0x%08h)",
                 name, got, exp, pat_idx, cur.instr);
        stop_with_failure();
    endtask

    // Register and data only matter when a writeback is expected
    task automatic check_wb(input logic got_en, input reg_idx_t got_reg, input word_t got_data,
                            input logic exp_en, input reg_idx_t exp_reg, input word_t exp_data);
        if (got_en !== exp_en) fail_on_mismatch("o_result.wb_en", got_en, exp_en);
        if (exp_en && got_reg !== exp_reg)
            fail_on_mismatch("o_result.wb_reg", got_reg, exp_reg);
        if (exp_en && got_data !== exp_data)
            fail_on_mismatch("o_result.wb_data", got_data, exp_data);
    endtask

    task automatic check_mem(input logic got_rd, input logic got_wr, input word_t got_addr,
                             input word_t got_data, input logic exp_rd, input logic exp_wr,
                             input word_t exp_addr, input word_t exp_data);
        if (got_rd !== exp_rd) fail_on_mismatch("o_result.mem_rd_en", got_rd, exp_rd);
        if (got_wr !== exp_wr) fail_on_mismatch("o_result.mem_wr_en", got_wr, exp_wr);
        if ((exp_rd || exp_wr) && got_addr !== exp_addr)
            fail_on_mismatch("o_result.mem_addr", got_addr, exp_addr);
        if (exp_wr && got_data !== exp_data)                // Store data only for SW
            fail_on_mismatch("o_result.mem_data", got_data, exp_data);
    endtask

    task automatic check_redirect(input logic got_flag, input word_t got_target,
                                  input logic exp_flag, input word_t exp_target);
        if (got_flag !== exp_flag) fail_on_mismatch("o_result.pc_redirect", got_flag, exp_flag);
        if (exp_flag && got_target !== exp_target)
            fail_on_mismatch("o_result.pc_target", got_target, exp_target);
    endtask

    task automatic check_halt(input logic got_halt, input logic exp_halt);
        if (got_halt !== exp_halt) fail_on_mismatch("o_result.halt", got_halt, exp_halt);
    endtask

    task automatic compare_result(input pattern_t p);
        check_wb(result.wb_en, result.wb_reg, result.wb_data,
                 p.exp.wb_en, p.exp.wb_reg, p.exp.wb_data);
        check_mem(result.mem_rd_en, result.mem_wr_en, result.mem_addr, result.mem_data,
                  p.exp.mem_rd_en, p.exp.mem_wr_en, p.exp.mem_addr, p.exp.mem_data);
        check_redirect(result.pc_redirect, result.pc_target, p.exp.pc_redirect, p.exp.pc_target);
        check_halt(result.halt, p.exp.halt);
    endtask

    function automatic pattern_t pattern_at(input int idx);
        pattern_t p;
        int       base;
        base              = idx * FIELDS;
        p.instr           = pat_words[base];
        p.rs_val          = pat_words[base + 1];
        p.rt_val          = pat_words[base + 2];
        p.pc_next         = pat_words[base + 3];
        p.exp.wb_en       = pat_words[base + 4][0];
        p.exp.wb_reg      = pat_words[base + 5][4:0];
        p.exp.wb_data     = pat_words[base + 6];
        p.exp.mem_rd_en   = pat_words[base + 7][0];
        p.exp.mem_wr_en   = pat_words[base + 8][0];
        p.exp.mem_addr    = pat_words[base + 9];
        p.exp.mem_data    = pat_words[base + 10];
        p.exp.pc_redirect = pat_words[base + 11][0];
        p.exp.pc_target   = pat_words[base + 12];
        p.exp.halt        = pat_words[base + 13][0];
        return p;
    endfunction

    // Called 1 ns after a rising edge with o_ack low, returns at the same phase
    task automatic run_exchange(input pattern_t p, input int hold_cycles);
        instr   = p.instr;
        rs_val  = p.rs_val;
        rt_val  = p.rt_val;
        pc_next = p.pc_next;
        req     = 1'b1;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (ack !== 1'b1);                       // Result is valid with the acknowledge
        compare_result(p);
        repeat (hold_cycles) begin                      // Upstream stalls with the request high
            @(posedge clk);
            #DRIVE_DELAY;
            if (ack !== 1'b1) fail_on_mismatch("o_ack", ack, 1'b1);
        end
        compare_result(p);                              // Result must survive the stall
        req = 1'b0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (ack !== 1'b0);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        req     = 1'b0;
        instr   = '0;
        rs_val  = '0;
        rt_val  = '0;
        pc_next = '0;
        pat_idx = 0;
        cur     = '0;
        pat_words[NUM_WORDS - 1] = '1;                  // Stays all ones if the file is short
        $readmemh(PATTERN_FILE, pat_words);
        if (pat_words[NUM_WORDS - 1] > 32'd1) begin
            $display("The pattern file %s is missing or holds fewer than %0d records",
                     PATTERN_FILE, NUM_PATTERNS);
            stop_with_failure();
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        for (int n = 0; n < NUM_PATTERNS; n++) begin
            pat_idx = n;
            cur     = pattern_at(n);
            run_exchange(cur, n % 3);                   // Stall of 0 to 2 cycles before req drops
        end
        repeat (2) @(posedge clk);                      // Last acknowledge drop gets its check
        #DRIVE_DELAY;
        if (dut0.u_handshake_sva.fail_count != 0) begin
            $display("The handshake assertions failed %0d times",
                     dut0.u_handshake_sva.fail_count);
            stop_with_failure();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verif/mips_exec_patterns.txt
// instr rs_val rt_val pc_next wb_en wb_reg wb_data mem_rd_en mem_wr_en mem_addr mem_data
// pc_redirect pc_target halt; fields behind a low enable are zero and are not compared
00221821 00001234 0000f00d 00400004 1 03 00010241 0 0 00000000 00000000 0 00000000 0 // ADDU
00221823 00000005 00000007 00400008 1 03 fffffffe 0 0 00000000 00000000 0 00000000 0 // SUBU
00221824 ff00ff00 0f0f0f0f 0040000c 1 03 0f000f00 0 0 00000000 00000000 0 00000000 0 // AND
00221826 ff00ff00 0f0f0f0f 00400010 1 03 f00ff00f 0 0 00000000 00000000 0 00000000 0 // XOR
00221827 ff00ff00 0f0f0f0f 00400014 1 03 00f000f0 0 0 00000000 00000000 0 00000000 0 // NOR
0022182a fffffffe 00000001 00400018 1 03 00000001 0 0 00000000 00000000 0 00000000 0 // SLT
00022100 12345678 80000001 0040001c 1 04 00000010 0 0 00000000 00000000 0 00000000 0 // SLL
00022202 00000000 80000000 00400020 1 04 00800000 0 0 00000000 00000000 0 00000000 0 // SRL
00022203 00000000 80000000 00400024 1 04 ff800000 0 0 00000000 00000000 0 00000000 0 // SRA
00222804 00000023 0000000f 00400028 1 05 00000078 0 0 00000000 00000000 0 00000000 0 // SLLV
00222807 00000024 80000010 0040002c 1 05 f8000001 0 0 00000000 00000000 0 00000000 0 // SRAV
2026fffc 00000010 00000000 00400030 1 06 0000000c 0 0 00000000 00000000 0 00000000 0 // ADDI
2826ffff fffffff0 00000000 00400034 1 06 00000001 0 0 00000000 00000000 0 00000000 0 // SLTI
34278001 12340000 00000000 00400038 1 07 12348001 0 0 00000000 00000000 0 00000000 0 // ORI
3c08abcd 11111111 00000000 0040003c 1 08 abcd0000 0 0 00000000 00000000 0 00000000 0 // LUI
8c29fff8 10000100 00000000 00400040 0 00 00000000 1 0 100000f8 00000000 0 00000000 0 // LW
ac220020 10000000 deadbeef 00400044 0 00 00000000 0 1 10000020 deadbeef 0 00000000 0 // SW
10220003 00000055 00000055 00400100 0 00 00000000 0 0 00000000 00000000 1 0040010c 0 // BEQ t
10220003 00000055 00000056 00400104 0 00 00000000 0 0 00000000 00000000 0 00000000 0 // BEQ n
1422fffe 00000001 00000002 00400200 0 00 00000000 0 0 00000000 00000000 1 004001f8 0 // BNE t
1422fffe 00000007 00000007 00400204 0 00 00000000 0 0 00000000 00000000 0 00000000 0 // BNE n
08100040 00000000 00000000 10000008 0 00 00000000 0 0 00000000 00000000 1 10400100 0 // J
0c100010 00000000 00000000 00400030 1 1f 00400030 0 0 00000000 00000000 1 00400040 0 // JAL
00200008 00400800 00000000 0040004c 0 00 00000000 0 0 00000000 00000000 1 00400800 0 // JR
00202009 00401000 00000000 00400050 1 04 00400050 0 0 00000000 00000000 1 00401000 0 // JALR
fc000000 00000000 00000000 00400054 0 00 00000000 0 0 00000000 00000000 0 00000000 1 // HALT
04000000 00000000 00000000 00400058 0 00 00000000 0 0 00000000 00000000 0 00000000 0 // Unknown
